//--- design/axi_bridge_pkg.sv
package axi_bridge_pkg;

    ////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////

    localparam int addr_w   = 32;
    localparam int data_w   = 64;
    localparam int strb_w   = 8;
    localparam int axi_id_w = 4;
    localparam int rq_depth = 4;
    localparam int rq_idx_w = 2;

    // log2 of the byte count, 0 to 3
    typedef logic [2:0] size_t;

    // full 8-byte beat
    localparam size_t bus_size = 3'd3;

    typedef enum logic {
        src_inst = 1'b0,
        src_data = 1'b1
    } rd_src_t;

    ////////////////////////////////////////
    // core side
    ////////////////////////////////////////

    typedef struct packed {
        logic [addr_w-1:0] addr;
        size_t             size;
        rd_src_t           src;
    } rd_req_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } rd_rsp_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        size_t             size;
    } wr_req_t;

    ////////////////////////////////////////
    // axi channels
    ////////////////////////////////////////

    typedef struct packed {
        logic [axi_id_w-1:0] id;
        logic [addr_w-1:0]   addr;
        size_t               size;
    } axi_ar_t;

    typedef struct packed {
        logic [axi_id_w-1:0] id;
        logic [data_w-1:0]   data;
        logic                last;
    } axi_r_t;

    typedef struct packed {
        logic [axi_id_w-1:0] id;
        logic [addr_w-1:0]   addr;
        size_t               size;
    } axi_aw_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [axi_id_w-1:0] id;
        logic [1:0]          resp;
    } axi_b_t;

endpackage

//--- design/axi_bridge_top.sv
`timescale 1ns/1ps

module axi_bridge_top (
    input  logic                              clk,
    input  logic                              rst,
    // instruction port
    input  logic                              i_i_en,
    input  logic [axi_bridge_pkg::addr_w-1:0] i_i_addr,
    output logic                              o_i_stall,
    output logic                              o_i_valid,
    output logic [axi_bridge_pkg::addr_w-1:0] o_i_addr,
    output logic [axi_bridge_pkg::data_w-1:0] o_i_data,
    // data port
    input  logic                              i_d_rd,
    input  logic                              i_d_wr,
    input  logic [axi_bridge_pkg::addr_w-1:0] i_d_addr,
    input  logic [axi_bridge_pkg::data_w-1:0] i_d_data,
    input  axi_bridge_pkg::size_t             i_d_size,
    output logic                              o_d_stall,
    output logic                              o_d_valid,
    output logic [axi_bridge_pkg::addr_w-1:0] o_d_addr,
    output logic [axi_bridge_pkg::data_w-1:0] o_d_data,
    // axi
    output axi_bridge_pkg::axi_ar_t           o_ar,
    output logic                              o_arvalid,
    input  logic                              i_arready,
    input  axi_bridge_pkg::axi_r_t            i_r,
    input  logic                              i_rvalid,
    output logic                              o_rready,
    output axi_bridge_pkg::axi_aw_t           o_aw,
    output logic                              o_awvalid,
    input  logic                              i_awready,
    output axi_bridge_pkg::axi_w_t            o_w,
    output logic                              o_wvalid,
    input  logic                              i_wready,
    input  axi_bridge_pkg::axi_b_t            i_b,
    input  logic                              i_bvalid,
    output logic                              o_bready
);

    axi_bridge_pkg::rd_req_t             enq_req;
    axi_bridge_pkg::rd_rsp_t             rsp;
    axi_bridge_pkg::wr_req_t             wr_req;
    logic [axi_bridge_pkg::rq_depth-1:0] war_hit;
    logic [axi_bridge_pkg::addr_w-1:0]   wb_addr;
    logic enq;
    logic queue_full;
    logic retire;
    logic wb_valid;
    logic d_stall_rd;
    logic d_stall_wr;

    assign wr_req.addr = i_d_addr;
    assign wr_req.data = i_d_data;
    assign wr_req.size = i_d_size;

    // both ports see the head entry, the valids tell them apart
    assign o_i_addr  = rsp.addr;
    assign o_i_data  = rsp.data;
    assign o_d_addr  = rsp.addr;
    assign o_d_data  = rsp.data;
    assign o_d_stall = d_stall_rd || d_stall_wr;

    read_port_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .i_i_en       (i_i_en),
        .i_i_addr     (i_i_addr),
        .i_d_rd       (i_d_rd),
        .i_d_addr     (i_d_addr),
        .i_d_size     (i_d_size),
        .i_queue_full (queue_full),
        .i_retire     (retire),
        .i_wb_valid   (wb_valid),
        .i_wb_addr    (wb_addr),
        .o_enq        (enq),
        .o_enq_req    (enq_req),
        .o_i_stall    (o_i_stall),
        .o_d_stall_rd (d_stall_rd)
    );

    read_queue u_read_queue (
        .clk       (clk),
        .rst       (rst),
        .i_enq     (enq),
        .i_enq_req (enq_req),
        .i_arready (i_arready),
        .i_r       (i_r),
        .i_rvalid  (i_rvalid),
        .i_wb_addr (wb_addr),
        .o_full    (queue_full),
        .o_retire  (retire),
        .o_rsp     (rsp),
        .o_i_valid (o_i_valid),
        .o_d_valid (o_d_valid),
        .o_ar      (o_ar),
        .o_arvalid (o_arvalid),
        .o_rready  (o_rready),
        .o_war_hit (war_hit)
    );

    write_buffer u_write_buffer (
        .clk          (clk),
        .rst          (rst),
        .i_d_wr       (i_d_wr),
        .i_wr_req     (wr_req),
        .i_war_hit    (war_hit),
        .i_awready    (i_awready),
        .i_wready     (i_wready),
        .i_b          (i_b),
        .i_bvalid     (i_bvalid),
        .o_d_stall_wr (d_stall_wr),
        .o_valid      (wb_valid),
        .o_addr       (wb_addr),
        .o_aw         (o_aw),
        .o_awvalid    (o_awvalid),
        .o_w          (o_w),
        .o_wvalid     (o_wvalid),
        .o_bready     (o_bready)
    );

endmodule

//--- design/read_port_arbiter.sv
`timescale 1ns/1ps

module read_port_arbiter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_i_en,
    input  logic [axi_bridge_pkg::addr_w-1:0] i_i_addr,
    input  logic                              i_d_rd,
    input  logic [axi_bridge_pkg::addr_w-1:0] i_d_addr,
    input  axi_bridge_pkg::size_t             i_d_size,
    input  logic                              i_queue_full,
    input  logic                              i_retire,
    input  logic                              i_wb_valid,
    input  logic [axi_bridge_pkg::addr_w-1:0] i_wb_addr,
    output logic                              o_enq,
    output axi_bridge_pkg::rd_req_t           o_enq_req,
    output logic                              o_i_stall,
    output logic                              o_d_stall_rd
);

    axi_bridge_pkg::rd_src_t last_src;
    logic raw_i;
    logic raw_d;
    logic no_room;
    logic want_i;
    logic want_d;
    logic grant_i;
    logic grant_d;

    // raw compare works on the beat address, so any overlapping write blocks the read
    assign raw_i = i_wb_valid && (i_wb_addr[axi_bridge_pkg::addr_w-1:axi_bridge_pkg::bus_size] ==
                                  i_i_addr[axi_bridge_pkg::addr_w-1:axi_bridge_pkg::bus_size]);
    assign raw_d = i_wb_valid && (i_wb_addr[axi_bridge_pkg::addr_w-1:axi_bridge_pkg::bus_size] ==
                                  i_d_addr[axi_bridge_pkg::addr_w-1:axi_bridge_pkg::bus_size]);

    // a retiring head frees its slot in the same cycle
    assign no_room = i_queue_full && !i_retire;

    assign want_i = i_i_en && !raw_i && !no_room;
    assign want_d = i_d_rd && !raw_d && !no_room;

    // alternate when both ports want the queue
    assign grant_i = want_i && (!want_d || last_src == axi_bridge_pkg::src_data);
    assign grant_d = want_d && !grant_i;

    assign o_enq        = grant_i || grant_d;
    assign o_i_stall    = i_i_en && !grant_i;
    assign o_d_stall_rd = i_d_rd && !grant_d;

    always_comb begin
        o_enq_req.addr = grant_i ? i_i_addr : i_d_addr;
        o_enq_req.size = grant_i ? axi_bridge_pkg::bus_size : i_d_size;
        o_enq_req.src  = grant_i ? axi_bridge_pkg::src_inst : axi_bridge_pkg::src_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_src <= axi_bridge_pkg::src_data;
        end else if (o_enq) begin
            last_src <= o_enq_req.src;
        end
    end

endmodule

//--- design/read_queue.sv
`timescale 1ns/1ps

module read_queue (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_enq,
    input  axi_bridge_pkg::rd_req_t           i_enq_req,
    input  logic                              i_arready,
    input  axi_bridge_pkg::axi_r_t            i_r,
    input  logic                              i_rvalid,
    input  logic [axi_bridge_pkg::addr_w-1:0] i_wb_addr,
    output logic                              o_full,
    output logic                              o_retire,
    output axi_bridge_pkg::rd_rsp_t           o_rsp,
    output logic                              o_i_valid,
    output logic                              o_d_valid,
    output axi_bridge_pkg::axi_ar_t           o_ar,
    output logic                              o_arvalid,
    output logic                              o_rready,
    output logic [axi_bridge_pkg::rq_depth-1:0] o_war_hit
);

    ////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////

    logic [axi_bridge_pkg::addr_w-1:0] ent_addr [axi_bridge_pkg::rq_depth];
    axi_bridge_pkg::size_t             ent_size [axi_bridge_pkg::rq_depth];
    axi_bridge_pkg::rd_src_t           ent_src  [axi_bridge_pkg::rq_depth];
    logic [axi_bridge_pkg::data_w-1:0] ent_data [axi_bridge_pkg::rq_depth];
    logic [axi_bridge_pkg::rq_depth-1:0] ent_valid;
    logic [axi_bridge_pkg::rq_depth-1:0] ent_done;

    // pointers carry one wrap bit above the index
    logic [axi_bridge_pkg::rq_idx_w:0]   tail_ptr;
    logic [axi_bridge_pkg::rq_idx_w:0]   issue_ptr;
    logic [axi_bridge_pkg::rq_idx_w:0]   head_ptr;
    logic [axi_bridge_pkg::rq_idx_w-1:0] tail_idx;
    logic [axi_bridge_pkg::rq_idx_w-1:0] issue_idx;
    logic [axi_bridge_pkg::rq_idx_w-1:0] head_idx;
    logic [axi_bridge_pkg::rq_idx_w-1:0] r_idx;
    logic ar_fire;
    logic r_fire;
    logic head_hit;

    assign tail_idx  = tail_ptr[axi_bridge_pkg::rq_idx_w-1:0];
    assign issue_idx = issue_ptr[axi_bridge_pkg::rq_idx_w-1:0];
    assign head_idx  = head_ptr[axi_bridge_pkg::rq_idx_w-1:0];
    assign r_idx     = i_r.id[axi_bridge_pkg::rq_idx_w-1:0];

    assign o_full = (tail_idx == head_idx) &&
                    (tail_ptr[axi_bridge_pkg::rq_idx_w] != head_ptr[axi_bridge_pkg::rq_idx_w]);

    ////////////////////////////////////////
    // ar issue
    ////////////////////////////////////////

    assign o_arvalid = (issue_ptr != tail_ptr);
    assign ar_fire   = o_arvalid && i_arready;

    always_comb begin
        o_ar.id   = {{(axi_bridge_pkg::axi_id_w - axi_bridge_pkg::rq_idx_w){1'b0}}, issue_idx};
        o_ar.addr = ent_addr[issue_idx];
        o_ar.size = ent_size[issue_idx];
    end

    ////////////////////////////////////////
    // completion and retirement
    ////////////////////////////////////////

    assign o_rready = 1'b1;
    assign r_fire   = i_rvalid && i_r.last;

    // a beat for the head bypasses the entry and retires at once
    assign head_hit = r_fire && (r_idx == head_idx);
    assign o_retire = ent_valid[head_idx] && (ent_done[head_idx] || head_hit);

    always_comb begin
        o_rsp.addr = ent_addr[head_idx];
        o_rsp.data = ent_done[head_idx] ? ent_data[head_idx] : i_r.data;
    end

    assign o_i_valid = o_retire && (ent_src[head_idx] == axi_bridge_pkg::src_inst);
    assign o_d_valid = o_retire && (ent_src[head_idx] == axi_bridge_pkg::src_data);

    // outstanding reads on the beat the buffered write targets
    always_comb begin
        for (int k = 0; k < axi_bridge_pkg::rq_depth; k++) begin
            o_war_hit[k] = ent_valid[k] && !ent_done[k] &&
                (ent_addr[k][axi_bridge_pkg::addr_w-1:axi_bridge_pkg::bus_size] ==
                 i_wb_addr[axi_bridge_pkg::addr_w-1:axi_bridge_pkg::bus_size]);
        end
    end

    always_ff @(posedge clk) begin
        if (i_enq) begin
            ent_addr[tail_idx] <= i_enq_req.addr;
            ent_size[tail_idx] <= i_enq_req.size;
            ent_src[tail_idx]  <= i_enq_req.src;
        end
        if (r_fire) begin
            ent_data[r_idx] <= i_r.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail_ptr  <= '0;
            issue_ptr <= '0;
            head_ptr  <= '0;
            ent_valid <= '0;
            ent_done  <= '0;
        end else begin
            if (r_fire && !head_hit) begin
                ent_done[r_idx] <= 1'b1;
            end
            if (o_retire) begin
                ent_valid[head_idx] <= 1'b0;
                ent_done[head_idx]  <= 1'b0;
                head_ptr            <= head_ptr + 1'b1;
            end
            // when full the new entry reuses the retiring slot, so it goes last
            if (i_enq) begin
                ent_valid[tail_idx] <= 1'b1;
                ent_done[tail_idx]  <= 1'b0;
                tail_ptr            <= tail_ptr + 1'b1;
            end
            if (ar_fire) begin
                issue_ptr <= issue_ptr + 1'b1;
            end
        end
    end

endmodule

//--- design/write_buffer.sv
`timescale 1ns/1ps

module write_buffer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_d_wr,
    input  axi_bridge_pkg::wr_req_t           i_wr_req,
    input  logic [axi_bridge_pkg::rq_depth-1:0] i_war_hit,
    input  logic                              i_awready,
    input  logic                              i_wready,
    input  axi_bridge_pkg::axi_b_t            i_b,
    input  logic                              i_bvalid,
    output logic                              o_d_stall_wr,
    output logic                              o_valid,
    output logic [axi_bridge_pkg::addr_w-1:0] o_addr,
    output axi_bridge_pkg::axi_aw_t           o_aw,
    output logic                              o_awvalid,
    output axi_bridge_pkg::axi_w_t            o_w,
    output logic                              o_wvalid,
    output logic                              o_bready
);

    axi_bridge_pkg::wr_req_t     wr_q;
    logic                        aw_sent;
    logic                        w_sent;
    logic                        b_done;
    logic                        accept;
    logic                        war_hold;
    logic [axi_bridge_pkg::strb_w-1:0] strb_base;

    // awid is always zero, so only that id completes the buffer
    assign b_done = o_valid && i_bvalid && (i_b.id == '0);
    assign accept = i_d_wr && (!o_valid || b_done);

    assign o_d_stall_wr = i_d_wr && o_valid && !b_done;
    assign o_addr       = wr_q.addr;
    assign o_bready     = 1'b1;

    // an older read to the same beat must see the old data first
    assign war_hold  = |i_war_hit;
    assign o_awvalid = o_valid && !aw_sent && !war_hold;
    assign o_wvalid  = o_valid && !w_sent && !war_hold;

    ////////////////////////////////////////
    // channel payloads
    ////////////////////////////////////////

    always_comb begin
        case (wr_q.size)
            3'd0:    strb_base = 8'h01;
            3'd1:    strb_base = 8'h03;
            3'd2:    strb_base = 8'h0f;
            default: strb_base = 8'hff;
        endcase
    end

    always_comb begin
        o_aw.id   = '0;
        o_aw.addr = wr_q.addr;
        o_aw.size = wr_q.size;
        o_w.data  = wr_q.data;
        o_w.strb  = strb_base << wr_q.addr[axi_bridge_pkg::bus_size-1:0];
        o_w.last  = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_q <= i_wr_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else if (accept) begin
            o_valid <= 1'b1;
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else begin
            if (b_done) begin
                o_valid <= 1'b0;
            end
            if (o_awvalid && i_awready) begin
                aw_sent <= 1'b1;
            end
            if (o_wvalid && i_wready) begin
                w_sent <= 1'b1;
            end
        end
    end

endmodule

//--- dv/axi_bridge_tb.sv
`timescale 1ns/1ps

module axi_bridge_tb;

    localparam int          n_tests  = 600;
    localparam logic [31:0] win_base = 32'h0000_1000;

    logic clk;
    logic rst;
    logic i_i_en;
    logic [31:0] i_i_addr;
    logic o_i_stall;
    logic o_i_valid;
    logic [31:0] o_i_addr;
    logic [63:0] o_i_data;
    logic i_d_rd;
    logic i_d_wr;
    logic [31:0] i_d_addr;
    logic [63:0] i_d_data;
    axi_bridge_pkg::size_t i_d_size;
    logic o_d_stall;
    logic o_d_valid;
    logic [31:0] o_d_addr;
    logic [63:0] o_d_data;
    axi_bridge_pkg::axi_ar_t ar;
    axi_bridge_pkg::axi_r_t  r;
    axi_bridge_pkg::axi_aw_t aw;
    axi_bridge_pkg::axi_w_t  w;
    axi_bridge_pkg::axi_b_t  b;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;

    int   seed = 64239;
    int   rnd;
    int   blk_cnt;
    logic i_acc;
    logic d_acc;
    logic ar_block;
    logic blk_phase;
    logic [7:0] model_mem [logic [31:0]];
    axi_bridge_pkg::rd_rsp_t exp_i [$];
    axi_bridge_pkg::rd_rsp_t exp_d [$];
    axi_bridge_pkg::rd_src_t order_q [$];
    axi_bridge_pkg::rd_rsp_t exp_e;
    axi_bridge_pkg::rd_rsp_t act_e;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    axi_bridge_top uut (
        .clk(clk), .rst(rst),
        .i_i_en(i_i_en), .i_i_addr(i_i_addr), .o_i_stall(o_i_stall),
        .o_i_valid(o_i_valid), .o_i_addr(o_i_addr), .o_i_data(o_i_data),
        .i_d_rd(i_d_rd), .i_d_wr(i_d_wr), .i_d_addr(i_d_addr), .i_d_data(i_d_data),
        .i_d_size(i_d_size), .o_d_stall(o_d_stall), .o_d_valid(o_d_valid),
        .o_d_addr(o_d_addr), .o_d_data(o_d_data),
        .o_ar(ar), .o_arvalid(arvalid), .i_arready(arready),
        .i_r(r), .i_rvalid(rvalid), .o_rready(rready),
        .o_aw(aw), .o_awvalid(awvalid), .i_awready(awready),
        .o_w(w), .o_wvalid(wvalid), .i_wready(wready),
        .i_b(b), .i_bvalid(bvalid), .o_bready(bready)
    );

    axi_slave_model slave (
        .clk(clk), .rst(rst), .i_ar_block(ar_block),
        .i_ar(ar), .i_arvalid(arvalid), .o_arready(arready),
        .o_r(r), .o_rvalid(rvalid),
        .i_aw(aw), .i_awvalid(awvalid), .o_awready(awready),
        .i_w(w), .i_wvalid(wvalid), .o_wready(wready),
        .o_b(b), .o_bvalid(bvalid)
    );

    ////////////////////////////////////////
    // reference memory
    ////////////////////////////////////////

    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [63:0] model_beat(input logic [31:0] a);
        logic [63:0] beat;
        logic [31:0] ba;
        for (int j = 0; j < 8; j++) begin
            ba = {a[31:3], 3'b000} + j;
            beat[8*j+:8] = model_mem.exists(ba) ? model_mem[ba] : fill_byte(ba);
        end
        return beat;
    endfunction

    // 1, 2, 4 or 8 enabled bytes starting at the low address bits
    task automatic model_write(input logic [31:0] a, input logic [63:0] d,
                               input axi_bridge_pkg::size_t sz);
        logic [7:0] strb;
        strb = (8'd1 << (8'd1 << sz[1:0])) - 8'd1;
        strb = (sz[1:0] == 2'd3) ? 8'hff : strb;
        strb = strb << a[2:0];
        for (int j = 0; j < 8; j++) begin
            if (strb[j]) begin
                model_mem[{a[31:3], 3'b000} + j] = d[8*j+:8];
            end
        end
    endtask

    // size aligned address inside a small window, so hazards are frequent
    function automatic logic [31:0] rand_addr(input axi_bridge_pkg::size_t sz);
        logic [31:0] r32;
        logic [4:0]  off;
        r32 = $random(seed);
        off = r32[4:0] & ~((5'd1 << sz[1:0]) - 5'd1);
        return win_base + {27'd0, off};
    endfunction

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_rsp(input string name, input axi_bridge_pkg::rd_rsp_t exp,
                             input axi_bridge_pkg::rd_rsp_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected addr %h data %h actual addr %h data %h",
                     name, exp.addr, exp.data, act.addr, act.data);
            fail_run("read response mismatch");
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            fail_run("stall mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            fail_run("handshake flag mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
            fail_run("count mismatch");
        end
    endtask

    ////////////////////////////////////////
    // monitor
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            // the bridge never back-pressures r or b
            check_flag("rready_high", 1'b1, rready);
            check_flag("bready_high", 1'b1, bready);
            if (o_i_valid) begin
                if (order_q.size() == 0 || order_q[0] != axi_bridge_pkg::src_inst) begin
                    fail_run("instruction result out of order or with no read outstanding");
                end
                act_e.addr = o_i_addr;
                act_e.data = o_i_data;
                check_rsp("inst_read", exp_i.pop_front(), act_e);
                void'(order_q.pop_front());
            end
            if (o_d_valid) begin
                if (order_q.size() == 0 || order_q[0] != axi_bridge_pkg::src_data) begin
                    fail_run("data result out of order or with no read outstanding");
                end
                act_e.addr = o_d_addr;
                act_e.data = o_d_data;
                check_rsp("data_read", exp_d.pop_front(), act_e);
                void'(order_q.pop_front());
            end
            if (blk_phase && i_i_en && blk_cnt == axi_bridge_pkg::rq_depth) begin
                check_stall("arready_low_full", 1'b1, o_i_stall);
            end
            // reads see the memory before a write accepted in the same cycle
            if (i_i_en && !o_i_stall) begin
                exp_e.addr = i_i_addr;
                exp_e.data = model_beat(i_i_addr);
                exp_i.push_back(exp_e);
                order_q.push_back(axi_bridge_pkg::src_inst);
                i_acc = 1'b1;
                if (blk_phase) begin
                    blk_cnt++;
                end
            end
            if (i_d_rd && !o_d_stall) begin
                exp_e.addr = i_d_addr;
                exp_e.data = model_beat(i_d_addr);
                exp_d.push_back(exp_e);
                order_q.push_back(axi_bridge_pkg::src_data);
                d_acc = 1'b1;
            end
            if (i_d_wr && !o_d_stall) begin
                model_write(i_d_addr, i_d_data, i_d_size);
                d_acc = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic drive_step();
        if (!i_i_en || i_acc) begin
            i_acc = 1'b0;
            rnd = $random(seed);
            i_i_en   = rnd[0] & rnd[1];
            i_i_addr = rand_addr(axi_bridge_pkg::bus_size);
        end
        if ((!i_d_rd && !i_d_wr) || d_acc) begin
            d_acc = 1'b0;
            rnd = $random(seed);
            i_d_rd   = (rnd[1:0] == 2'd1);
            i_d_wr   = (rnd[1:0] == 2'd2);
            i_d_size = {1'b0, rnd[3:2]};
            i_d_addr = rand_addr(i_d_size);
            i_d_data = {$random(seed), $random(seed)};
        end
    endtask

    task automatic drain();
        while (i_i_en || i_d_rd || i_d_wr) begin
            @(negedge clk);
            if (i_acc) begin
                i_i_en = 1'b0;
            end
            if (d_acc) begin
                i_d_rd = 1'b0;
                i_d_wr = 1'b0;
            end
        end
        while (order_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
    endtask

    initial begin
        rst = 1'b1;
        i_i_en = 1'b0;
        i_i_addr = '0;
        i_d_rd = 1'b0;
        i_d_wr = 1'b0;
        i_d_addr = '0;
        i_d_data = '0;
        i_d_size = '0;
        ar_block = 1'b0;
        blk_phase = 1'b0;
        blk_cnt = 0;
        i_acc = 1'b0;
        d_acc = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // requests in the first cycle out of reset must go through at once
        i_i_en   = 1'b1;
        i_i_addr = rand_addr(axi_bridge_pkg::bus_size);
        i_d_wr   = 1'b1;
        i_d_size = axi_bridge_pkg::bus_size;
        i_d_addr = rand_addr(axi_bridge_pkg::bus_size);
        i_d_data = {$random(seed), $random(seed)};
        #1;
        check_stall("reset_i_stall", 1'b0, o_i_stall);
        check_stall("reset_d_stall", 1'b0, o_d_stall);
        check_flag("reset_arvalid", 1'b0, arvalid);
        check_flag("reset_awvalid", 1'b0, awvalid);
        check_flag("reset_wvalid", 1'b0, wvalid);
        check_flag("reset_i_valid", 1'b0, o_i_valid);
        check_flag("reset_d_valid", 1'b0, o_d_valid);
        for (int t = 0; t < n_tests; t++) begin
            @(negedge clk);
            drive_step();
        end
        drain();
        // hold arready low and fill the queue
        ar_block = 1'b1;
        blk_phase = 1'b1;
        blk_cnt = 0;
        repeat (10) begin
            @(negedge clk);
            if (!i_i_en || i_acc) begin
                i_acc = 1'b0;
                i_i_en = 1'b1;
                i_i_addr = rand_addr(axi_bridge_pkg::bus_size);
            end
        end
        check_count("arready_low_accepts", axi_bridge_pkg::rq_depth, blk_cnt);
        ar_block = 1'b0;
        blk_phase = 1'b0;
        drain();
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #(n_tests * 40 * 20);
        fail_run("watchdog timeout, the run did not finish in time");
    end

endmodule

//--- dv/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model #(
    parameter int seed_init = 64239
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_ar_block,
    input  axi_bridge_pkg::axi_ar_t i_ar,
    input  logic                    i_arvalid,
    output logic                    o_arready,
    output axi_bridge_pkg::axi_r_t  o_r,
    output logic                    o_rvalid,
    input  axi_bridge_pkg::axi_aw_t i_aw,
    input  logic                    i_awvalid,
    output logic                    o_awready,
    input  axi_bridge_pkg::axi_w_t  i_w,
    input  logic                    i_wvalid,
    output logic                    o_wready,
    output axi_bridge_pkg::axi_b_t  o_b,
    output logic                    o_bvalid
);

    logic [7:0]  mem [logic [31:0]];
    logic [3:0]  pend_id [$];
    logic [63:0] pend_data [$];
    axi_bridge_pkg::axi_aw_t aw_q;
    axi_bridge_pkg::axi_w_t  w_q;
    logic aw_got;
    logic w_got;
    int   seed = seed_init;
    int   rnd;
    int   k;

    // untouched bytes hold a pattern of their full address
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [63:0] read_beat(input logic [31:0] a);
        logic [63:0] beat;
        logic [31:0] ba;
        for (int j = 0; j < 8; j++) begin
            ba = {a[31:3], 3'b000} + j;
            beat[8*j+:8] = mem.exists(ba) ? mem[ba] : fill_byte(ba);
        end
        return beat;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            o_arready <= 1'b0;
            o_awready <= 1'b0;
            o_wready  <= 1'b0;
            o_rvalid  <= 1'b0;
            o_bvalid  <= 1'b0;
            o_r       <= '0;
            o_b       <= '0;
            aw_got = 1'b0;
            w_got  = 1'b0;
            pend_id.delete();
            pend_data.delete();
        end else begin
            // read data is taken when the address is accepted
            if (i_arvalid && o_arready) begin
                pend_id.push_back(i_ar.id);
                pend_data.push_back(read_beat(i_ar.addr));
            end
            if (i_awvalid && o_awready) begin
                aw_q   = i_aw;
                aw_got = 1'b1;
            end
            if (i_wvalid && o_wready) begin
                w_q   = i_w;
                w_got = 1'b1;
            end
            o_bvalid <= 1'b0;
            if (aw_got && w_got) begin
                for (int j = 0; j < 8; j++) begin
                    if (w_q.strb[j]) begin
                        mem[{aw_q.addr[31:3], 3'b000} + j] = w_q.data[8*j+:8];
                    end
                end
                o_b.id   <= aw_q.id;
                o_b.resp <= 2'b00;
                o_bvalid <= 1'b1;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
            rnd = $random(seed);
            o_arready <= !i_ar_block && rnd[0];
            o_awready <= rnd[1];
            o_wready  <= rnd[2];
            // pick any outstanding read, so responses come back out of order
            o_rvalid <= 1'b0;
            if (pend_id.size() != 0 && rnd[4:3] != 2'b00) begin
                k = rnd[15:8] % pend_id.size();
                o_r.id   <= pend_id[k];
                o_r.data <= pend_data[k];
                o_r.last <= 1'b1;
                o_rvalid <= 1'b1;
                pend_id.delete(k);
                pend_data.delete(k);
            end
        end
    end

endmodule

//--- project.f
design/axi_bridge_pkg.sv
design/read_port_arbiter.sv
design/read_queue.sv
design/write_buffer.sv
design/axi_bridge_top.sv
dv/axi_slave_model.sv
dv/axi_bridge_tb.sv

//--- run.sh
#!/bin/bash
# build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -f sim.log
verilator --binary --timing --top-module axi_bridge_tb -f project.f -o axi_bridge_sim \
    && ./obj_dir/axi_bridge_sim 2>&1 | tee sim.log \
    || echo "simulation did not complete" >> sim.log
grep -q "Result: FAILED" sim.log && exit 1 || grep -q "Result: PASSED" sim.log || exit 1
exit 0
